// File: hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic           clk,
    input  logic           aluStart,
    input  cpuPkg::aluOp_t aluOp,
    input  cpuPkg::word_t  rsData,
    input  cpuPkg::word_t  rtData,
    input  cpuPkg::imm_t   imm,
    input  logic [4:0]     shamt,
    input  logic           useImm,
    input  logic           zeroExtend,
    input  logic           isLoad,
    input  logic           isStore,
    input  cpuPkg::word_t  readdata,
    output cpuPkg::word_t  result,
    output cpuPkg::word_t  effAddr
);
    import cpuPkg::*;

    word_t      signImm;
    word_t      extImm;
    word_t      operandB;
    word_t      value;
    logic [4:0] shiftAmount;

    assign signImm  = {{16{imm[15]}}, imm};
    assign extImm   = zeroExtend ? {16'h0000, imm} : signImm;
    assign operandB = useImm ? extImm : rtData;

    // useImm on a shift selects shamt, otherwise the low bits of rs
    assign shiftAmount = useImm ? shamt : rsData[4:0];

    always_comb begin
        case (aluOp)
            AluAdd:  value = rsData + operandB;
            AluSub:  value = rsData - operandB;
            AluAnd:  value = rsData & operandB;
            AluOr:   value = rsData | operandB;
            AluXor:  value = rsData ^ operandB;
            AluSlt:  value = {31'd0, $signed(rsData) < $signed(operandB)};
            AluSltu: value = {31'd0, rsData < operandB};
            AluSll:  value = rtData << shiftAmount;
            AluSrl:  value = rtData >> shiftAmount;
            AluSra:  value = $signed(rtData) >>> shiftAmount;
            AluLui:  value = {imm, 16'h0000};
            default: value = '0;
        endcase
    end

    // For a load the result tracks readdata through the memory step,
    // so the word from the completing edge is what write-back sees
    always_ff @(posedge clk) begin
        if (aluStart) begin
            result <= value;
        end else if (isLoad) begin
            result <= readdata;
        end
    end

    always_ff @(posedge clk) begin
        if (aluStart && (isLoad || isStore)) begin
            effAddr <= rsData + signImm;
        end
    end

endmodule

// File: hw/branchUnit.sv
`timescale 1ns/1ps

module branchUnit #(
    parameter cpuPkg::word_t resetVector = cpuPkg::ResetVector
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            pcAdvance,
    input  logic            isBranch,
    input  logic            isJump,
    input  logic            isJr,
    input  logic            aluStart,
    input  cpuPkg::opcode_t opcode,
    input  cpuPkg::word_t   rsData,
    input  cpuPkg::word_t   rtData,
    input  cpuPkg::imm_t    imm,
    input  logic [25:0]     target,
    output cpuPkg::word_t   pc,
    output logic            haltNow
);
    import cpuPkg::*;

    word_t pendingTarget;
    word_t branchTarget;
    word_t jumpTarget;
    word_t takenTarget;
    logic  pending;
    logic  taken;

    // pc already points at the delay slot when the branch executes
    assign branchTarget = pc + {{14{imm[15]}}, imm, 2'b00};
    assign jumpTarget   = {pc[31:28], target, 2'b00};
    assign takenTarget  = isJr ? rsData : (isJump ? jumpTarget : branchTarget);

    // BEQ wants equal operands, BNE unequal ones
    assign taken = isJr || isJump || (isBranch && ((opcode == OpBeq) == (rsData == rtData)));

    // pc moves on each completed fetch, so a recorded target
    // takes effect after the delay-slot instruction is fetched
    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= resetVector;
            pending <= 1'b0;
        end else begin
            if (pcAdvance) begin
                pc      <= pending ? pendingTarget : pc + 32'd4;
                pending <= 1'b0;
            end
            if (aluStart && taken) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aluStart && taken) begin
            pendingTarget <= takenTarget;
        end
    end

    assign haltNow = (pc == HaltAddress);

endmodule

// File: hw/busController.sv
`timescale 1ns/1ps

module busController (
    input  logic          clk,
    input  logic          reset,
    input  logic          fetchReq,
    input  logic          loadReq,
    input  logic          storeReq,
    input  cpuPkg::word_t pc,
    input  cpuPkg::word_t effAddr,
    input  cpuPkg::word_t rtData,
    input  logic          waitrequest,
    output cpuPkg::word_t address,
    output logic          read,
    output logic          write,
    output cpuPkg::word_t writedata,
    output logic [3:0]    byteenable,
    output logic          busDone
);

    logic busy;
    logic starting;

    assign busy     = read || write;
    assign starting = !busy && (fetchReq || loadReq || storeReq);

    // Transfer completes on the first edge without waitrequest
    assign busDone = busy && !waitrequest;

    // Only whole words are moved
    assign byteenable = 4'b1111;

    always_ff @(posedge clk) begin
        if (reset) begin
            read  <= 1'b0;
            write <= 1'b0;
        end else if (busDone) begin
            read  <= 1'b0;
            write <= 1'b0;
        end else if (starting) begin
            read  <= fetchReq || loadReq;
            write <= storeReq;
        end
    end

    // Address and data held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (starting) begin
            address   <= fetchReq ? pc : effAddr;
            writedata <= rtData;
        end
    end

endmodule

// File: hw/cpuControl.sv
`timescale 1ns/1ps

module cpuControl (
    input  logic clk,
    input  logic reset,
    input  logic busDone,
    input  logic isLoad,
    input  logic isStore,
    input  logic isBranch,
    input  logic isJump,
    input  logic isJr,
    input  logic haltNow,
    output logic fetchReq,
    output logic loadReq,
    output logic storeReq,
    output logic irLoad,
    output logic aluStart,
    output logic regWrite,
    output logic pcAdvance,
    output logic active
);
    import cpuPkg::*;

    cpuState_t state;
    cpuState_t nextState;
    cpuState_t doneState;
    logic      isMemOp;

    assign isMemOp = isLoad || isStore;

    // Where an instruction goes once it is finished
    assign doneState = haltNow ? StHalt : StFetch;

    always_comb begin
        nextState = state;
        case (state)
            StFetch: begin
                if (busDone) begin
                    nextState = StDecode;
                end
            end
            StDecode: nextState = StExecute;
            StExecute: begin
                if (isMemOp) begin
                    nextState = StMemory;
                end else if (isBranch || isJump || isJr) begin
                    nextState = doneState;
                end else begin
                    nextState = StWriteBack;
                end
            end
            StMemory: begin
                if (busDone) begin
                    nextState = isLoad ? StWriteBack : doneState;
                end
            end
            StWriteBack: nextState = doneState;
            default: nextState = StHalt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= StFetch;
            active <= 1'b1;
        end else begin
            state  <= nextState;
            active <= (nextState != StHalt);
        end
    end

    assign fetchReq = (state == StFetch);
    assign loadReq  = (state == StMemory) && isLoad;
    assign storeReq = (state == StMemory) && isStore;
    assign aluStart = (state == StExecute);
    assign regWrite = (state == StWriteBack);

    // Instruction word and pc both move on the completed fetch
    assign irLoad    = fetchReq && busDone;
    assign pcAdvance = fetchReq && busDone;

endmodule

// File: hw/cpuPkg.sv
package cpuPkg;

    // Basic word and field widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [15:0] imm_t;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OpSpecial = 6'd0,
        OpJ       = 6'd2,
        OpBeq     = 6'd4,
        OpBne     = 6'd5,
        OpAddiu   = 6'd9,
        OpSlti    = 6'd10,
        OpSltiu   = 6'd11,
        OpAndi    = 6'd12,
        OpOri     = 6'd13,
        OpXori    = 6'd14,
        OpLui     = 6'd15,
        OpLw      = 6'd35,
        OpSw      = 6'd43
    } opcode_t;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FnSll  = 6'd0,
        FnSrl  = 6'd2,
        FnSra  = 6'd3,
        FnSllv = 6'd4,
        FnSrlv = 6'd6,
        FnSrav = 6'd7,
        FnJr   = 6'd8,
        FnAddu = 6'd33,
        FnSubu = 6'd35,
        FnAnd  = 6'd36,
        FnOr   = 6'd37,
        FnXor  = 6'd38,
        FnSlt  = 6'd42,
        FnSltu = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSltu,
        AluSll,
        AluSrl,
        AluSra,
        AluLui
    } aluOp_t;

    // One step of the multicycle instruction sequence
    typedef enum logic [2:0] {
        StFetch,
        StDecode,
        StExecute,
        StMemory,
        StWriteBack,
        StHalt
    } cpuState_t;

    localparam word_t ResetVector = 32'hBFC0_0000;
    // A fetch from here stops the processor
    localparam word_t HaltAddress = 32'h0000_0000;

endpackage

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic             clk,
    input  logic             irLoad,
    input  cpuPkg::word_t    readdata,
    output cpuPkg::regAddr_t rs,
    output cpuPkg::regAddr_t rt,
    output cpuPkg::regAddr_t writeReg,
    output cpuPkg::imm_t     imm,
    output logic [4:0]       shamt,
    output cpuPkg::aluOp_t   aluOp,
    output logic             useImm,
    output logic             zeroExtend,
    output logic             isLoad,
    output logic             isStore,
    output logic             isBranch,
    output logic             isJump,
    output logic             isJr,
    output logic             isRtype,
    output cpuPkg::opcode_t  opcode,
    output logic [25:0]      target
);
    import cpuPkg::*;

    word_t    instr;
    funct_t   funct;
    regAddr_t rd;

    // Instruction register, loaded when the fetch completes
    always_ff @(posedge clk) begin
        if (irLoad) begin
            instr <= readdata;
        end
    end

    assign opcode = opcode_t'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = funct_t'(instr[5:0]);
    assign imm    = instr[15:0];
    assign target = instr[25:0];

    // Anything not listed writes register zero, which makes it a no-op
    always_comb begin
        aluOp      = AluAdd;
        useImm     = 1'b0;
        zeroExtend = 1'b0;
        isLoad     = 1'b0;
        isStore    = 1'b0;
        isBranch   = 1'b0;
        isJump     = 1'b0;
        isJr       = 1'b0;
        isRtype    = 1'b0;
        writeReg   = '0;
        case (opcode)
            OpSpecial: begin
                isRtype  = 1'b1;
                writeReg = rd;
                case (funct)
                    FnAddu: aluOp = AluAdd;
                    FnSubu: aluOp = AluSub;
                    FnAnd:  aluOp = AluAnd;
                    FnOr:   aluOp = AluOr;
                    FnXor:  aluOp = AluXor;
                    FnSlt:  aluOp = AluSlt;
                    FnSltu: aluOp = AluSltu;
                    // Fixed shifts take the amount from the instruction word
                    FnSll: begin
                        aluOp  = AluSll;
                        useImm = 1'b1;
                    end
                    FnSrl: begin
                        aluOp  = AluSrl;
                        useImm = 1'b1;
                    end
                    FnSra: begin
                        aluOp  = AluSra;
                        useImm = 1'b1;
                    end
                    FnSllv: aluOp = AluSll;
                    FnSrlv: aluOp = AluSrl;
                    FnSrav: aluOp = AluSra;
                    FnJr: begin
                        isJr     = 1'b1;
                        writeReg = '0;
                    end
                    default: writeReg = '0;
                endcase
            end
            OpJ: isJump = 1'b1;
            OpBeq, OpBne: isBranch = 1'b1;
            OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui: begin
                useImm   = 1'b1;
                writeReg = rt;
                case (opcode)
                    OpSlti:  aluOp = AluSlt;
                    OpSltiu: aluOp = AluSltu;
                    OpAndi:  aluOp = AluAnd;
                    OpOri:   aluOp = AluOr;
                    OpXori:  aluOp = AluXor;
                    OpLui:   aluOp = AluLui;
                    default: aluOp = AluAdd;
                endcase
                // Logic immediates are unsigned
                zeroExtend = (opcode == OpAndi) || (opcode == OpOri) || (opcode == OpXori);
            end
            OpLw: begin
                isLoad   = 1'b1;
                useImm   = 1'b1;
                writeReg = rt;
            end
            OpSw: begin
                isStore = 1'b1;
                useImm  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/mipsCpuBus.sv
`timescale 1ns/1ps

module mipsCpuBus #(
    parameter cpuPkg::word_t resetVector = cpuPkg::ResetVector
) (
    input  logic          clk,
    input  logic          reset,
    output logic          active,
    output cpuPkg::word_t registerV0,
    output cpuPkg::word_t address,
    output logic          write,
    output logic          read,
    input  logic          waitrequest,
    output cpuPkg::word_t writedata,
    output logic [3:0]    byteenable,
    input  cpuPkg::word_t readdata
);
    import cpuPkg::*;

    // Control handshakes
    logic fetchReq;
    logic loadReq;
    logic storeReq;
    logic busDone;
    logic irLoad;
    logic aluStart;
    logic regWrite;
    logic pcAdvance;
    logic haltNow;

    // Decoded instruction
    logic        isLoad;
    logic        isStore;
    logic        isBranch;
    logic        isJump;
    logic        isJr;
    logic        useImm;
    logic        zeroExtend;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    writeReg;
    imm_t        imm;
    logic [4:0]  shamt;
    logic [25:0] target;
    aluOp_t      aluOp;
    opcode_t     opcode;

    // Datapath values
    word_t rsData;
    word_t rtData;
    word_t result;
    word_t effAddr;
    word_t pc;

    cpuControl control (
        .clk       (clk),
        .reset     (reset),
        .busDone   (busDone),
        .isLoad    (isLoad),
        .isStore   (isStore),
        .isBranch  (isBranch),
        .isJump    (isJump),
        .isJr      (isJr),
        .haltNow   (haltNow),
        .fetchReq  (fetchReq),
        .loadReq   (loadReq),
        .storeReq  (storeReq),
        .irLoad    (irLoad),
        .aluStart  (aluStart),
        .regWrite  (regWrite),
        .pcAdvance (pcAdvance),
        .active    (active)
    );

    instrDecoder decoder (
        .clk        (clk),
        .irLoad     (irLoad),
        .readdata   (readdata),
        .rs         (rs),
        .rt         (rt),
        .writeReg   (writeReg),
        .imm        (imm),
        .shamt      (shamt),
        .aluOp      (aluOp),
        .useImm     (useImm),
        .zeroExtend (zeroExtend),
        .isLoad     (isLoad),
        .isStore    (isStore),
        .isBranch   (isBranch),
        .isJump     (isJump),
        .isJr       (isJr),
        .isRtype    (),
        .opcode     (opcode),
        .target     (target)
    );

    registerFile regs (
        .clk        (clk),
        .reset      (reset),
        .regWrite   (regWrite),
        .rs         (rs),
        .rt         (rt),
        .writeReg   (writeReg),
        .writeData  (result),
        .rsData     (rsData),
        .rtData     (rtData),
        .registerV0 (registerV0)
    );

    aluUnit alu (
        .clk        (clk),
        .aluStart   (aluStart),
        .aluOp      (aluOp),
        .rsData     (rsData),
        .rtData     (rtData),
        .imm        (imm),
        .shamt      (shamt),
        .useImm     (useImm),
        .zeroExtend (zeroExtend),
        .isLoad     (isLoad),
        .isStore    (isStore),
        .readdata   (readdata),
        .result     (result),
        .effAddr    (effAddr)
    );

    branchUnit #(
        .resetVector (resetVector)
    ) branch (
        .clk       (clk),
        .reset     (reset),
        .pcAdvance (pcAdvance),
        .isBranch  (isBranch),
        .isJump    (isJump),
        .isJr      (isJr),
        .aluStart  (aluStart),
        .opcode    (opcode),
        .rsData    (rsData),
        .rtData    (rtData),
        .imm       (imm),
        .target    (target),
        .pc        (pc),
        .haltNow   (haltNow)
    );

    busController bus (
        .clk         (clk),
        .reset       (reset),
        .fetchReq    (fetchReq),
        .loadReq     (loadReq),
        .storeReq    (storeReq),
        .pc          (pc),
        .effAddr     (effAddr),
        .rtData      (rtData),
        .waitrequest (waitrequest),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .busDone     (busDone)
    );

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic             clk,
    input  logic             reset,
    input  logic             regWrite,
    input  cpuPkg::regAddr_t rs,
    input  cpuPkg::regAddr_t rt,
    input  cpuPkg::regAddr_t writeReg,
    input  cpuPkg::word_t    writeData,
    output cpuPkg::word_t    rsData,
    output cpuPkg::word_t    rtData,
    output cpuPkg::word_t    registerV0
);
    import cpuPkg::*;

    word_t regs [32];

    // Register zero is cleared here and never written again
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (writeReg != '0)) begin
            regs[writeReg] <= writeData;
        end
    end

    // Both read ports are combinational
    assign rsData = regs[rs];
    assign rtData = regs[rt];

    // v0 is register 2
    assign registerV0 = regs[2];

endmodule

// File: run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f src.f --top-module mipsCpuBusTb -o simv; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed!"; then
    exit 0
fi

exit 1

// File: src.f
+incdir+tb
hw/cpuPkg.sv
hw/instrDecoder.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/branchUnit.sv
hw/busController.sv
hw/cpuControl.sv
hw/mipsCpuBus.sv
tb/mipsCpuBusTb.sv

// File: tb/testPrograms.svh
`ifndef TEST_PROGRAMS_SVH
`define TEST_PROGRAMS_SVH

// Columns 0 to 11 hold the program words placed at the reset vector.
// Column 12 is the data word at 100 hex, 13 the expected v0, 14 the
// expected final data word.
localparam int NumTests = 10;
localparam int RowWords = 15;

localparam logic [31:0] TestTable [NumTests][RowWords] = '{
    // ADDU and SUBU with a negative operand
    '{32'h24080005, 32'h2409FFFD, 32'h01095023, 32'h01481021,
      32'h00000008, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h0BAD0001, 32'h0000000D, 32'h0BAD0001},
    // LUI, ORI, AND, XOR, OR
    '{32'h3C08F0F0, 32'h350880FF, 32'h3C09FF00, 32'h01095024,
      32'h01481026, 32'h00491025, 32'h00000008, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h0BAD0002, 32'hFFF080FF, 32'h0BAD0002},
    // Signed and unsigned SLT on -1 and 1, then SLL
    '{32'h2408FFFF, 32'h24090001, 32'h0109502A, 32'h0128482B,
      32'h000A1100, 32'h00491021, 32'h00000008, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h0BAD0003, 32'h00000011, 32'h0BAD0003},
    // Fixed and variable shifts
    '{32'h3C088000, 32'h35080010, 32'h00084903, 32'h00085202,
      32'h24020003, 32'h00494807, 32'h004A5006, 32'h00484004,
      32'h012A1025, 32'h00481021, 32'h00000008, 32'h00000000,
      32'h0BAD0004, 32'hFF100080, 32'h0BAD0004},
    // Immediate extension: ADDIU, ANDI, XORI, SLTIU, SLTI
    '{32'h24088001, 32'h3109FFFF, 32'h390A8000, 32'h2D288000,
      32'h2929FFFF, 32'h01481021, 32'h00491021, 32'h00000008,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h0BAD0005, 32'hFFFF0002, 32'h0BAD0005},
    // SW through a base register, then LW back
    '{32'h3C081234, 32'h35085678, 32'h24090080, 32'hAD280080,
      32'h8C020100, 32'h00000008, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h11112222, 32'h12345678, 32'h12345678},
    // LW, use of the loaded value, SW
    '{32'h8C080100, 32'h25020001, 32'hAC020100, 32'h00000008,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h000000FF, 32'h00000100, 32'h00000100},
    // Taken BEQ, taken BNE, untaken BEQ, each with a delay slot
    '{32'h24080001, 32'h11080002, 32'h24020010, 32'h24420100,
      32'h15000002, 32'h24420001, 32'h24420100, 32'h11000001,
      32'h24420002, 32'h24420020, 32'h00000008, 32'h00000000,
      32'h0BAD0008, 32'h00000033, 32'h0BAD0008},
    // Untaken BNE, J, and the delay slot of JR
    '{32'h14000005, 32'h24020004, 32'h0BF00005, 32'h24420008,
      32'h24420100, 32'h00000008, 32'h24420001, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h0BAD0009, 32'h0000000D, 32'h0BAD0009},
    // Writes to register zero, then v0 copied from it
    '{32'h24020007, 32'h24000005, 32'h3C00FFFF, 32'h00001021,
      32'h00000008, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h0BAD000A, 32'h00000000, 32'h0BAD000A}
};

`endif

// File: tb/mipsCpuBusTb.sv
`timescale 1ns/1ps

module mipsCpuBusTb;

    `include "testPrograms.svh"

    localparam logic [31:0] ProgramBase   = 32'hBFC0_0000;
    localparam logic [31:0] DataAddress   = 32'h0000_0100;
    localparam int          TimeoutCycles = NumTests * 12 * 12;

    logic        clk;
    logic        reset;
    logic        waitrequest = 1'b1;
    logic [31:0] readdata = '0;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    // Sparse word memory
    logic [31:0] mem [logic [31:0]];

    integer seed = 32'h2005;
    int     errorCount = 0;
    int     passCount = 0;
    int     cycles = 0;
    logic   pending = 1'b0;
    int     waitCount = 0;

    mipsCpuBus #(
        .resetVector (ProgramBase)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .registerV0  (registerV0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Unwritten words read back as a pattern of their address
    function automatic logic [31:0] readWord(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'hA5A5_5A5A;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            errorCount++;
        end
    endtask

    // Bus slave with 0 to 2 extra wait cycles per transfer
    always @(posedge clk) begin
        int waits;
        if (reset) begin
            pending     = 1'b0;
            waitrequest <= 1'b1;
        end else if ((read || write) && !waitrequest) begin
            if (write) begin
                mem[address] = writedata;
            end
            pending     = 1'b0;
            waitrequest <= 1'b1;
        end else if ((read || write) && !pending) begin
            pending = 1'b1;
            checkValue("byteenable", {28'd0, byteenable}, 32'h0000_000F);
            if (read && (address == 32'h0)) begin
                $display("Read issued to address zero");
                errorCount++;
            end
            readdata <= readWord(address);
            waits = {$random(seed)} % 3;
            if (waits == 0) begin
                waitrequest <= 1'b0;
            end else begin
                waitCount = waits;
            end
        end else if (pending) begin
            waitCount = waitCount - 1;
            if (waitCount == 0) begin
                waitrequest <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            $display("Timeout: the run went past %0d cycles", TimeoutCycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int errorsBefore;
        reset = 1'b1;
        for (int t = 0; t < NumTests; t++) begin
            errorsBefore = errorCount;
            mem.delete();
            for (int i = 0; i < 12; i++) begin
                mem[ProgramBase + 32'(4 * i)] = TestTable[t][i];
            end
            mem[DataAddress] = TestTable[t][12];

            @(posedge clk);
            reset <= 1'b1;
            repeat (3) @(posedge clk);
            reset <= 1'b0;

            // Run until the processor halts
            do begin
                @(posedge clk);
            end while (active !== 1'b0);

            checkValue("registerV0", registerV0, TestTable[t][13]);
            checkValue("mem[100]", readWord(DataAddress), TestTable[t][14]);
            if (errorCount == errorsBefore) begin
                passCount++;
                $display("Test %0d passed", t);
            end else begin
                $display("Test %0d failed", t);
            end
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 NumTests, passCount, NumTests - passCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
